// ==== dv/rsa_core_golden.txt ====
# T name k a_route b_route wb_route use_const back_to_back, C const words 0..3
# D tb lanes 0..3 then cb lanes 0..3, E expected result row i columns 0..3
T fwd_routes 4 0 0 0 0 0
C 0 0 0 0
D 1 2 3 4 9 9 9 9
D 0 1 0 1 9 9 9 9
D 2 0 1 0 9 9 9 9
D 1 1 1 1 9 9 9 9
E 6 3 6 5
E 3 6 7 a
E 6 7 b d
E 5 a d 12
T rev_cb 2 1 2 3 0 0
C 0 0 0 0
D 1 2 3 4 1 0 2 0
D 5 6 7 8 0 1 0 3
E 4 8 8 18
E 3 7 6 15
E 2 6 4 12
E 1 5 2 f
T const_b 2 0 2 1 1 0
C 2 3 1 4
D 1 1 1 1 7 7 7 7
D 1 2 3 4 9 9 9 9
E 4 6 2 8
E 6 9 3 c
E 8 c 4 10
E a f 5 14
T b2b_first 4 0 2 0 0 0
C 0 0 0 0
D 1 0 0 0 1 2 3 4
D 0 1 0 0 5 6 7 8
D 0 0 1 0 9 a b c
D 0 0 0 1 d e f 10
E 1 2 3 4
E 5 6 7 8
E 9 a b c
E d e f 10
T b2b_second 4 0 2 0 0 1
C 0 0 0 0
D 1 1 1 1 1 0 0 0
D 1 1 1 1 0 1 0 0
D 1 1 1 1 0 0 1 0
D 1 1 1 1 0 0 0 2
E 1 1 1 2
E 1 1 1 2
E 1 1 1 2
E 1 1 1 2
T wrap 2 0 2 2 0 0
C 0 0 0 0
D ffff 8000 1234 0100 ffff 0002 0010 0100
D ffff 0002 0001 0100 0001 8000 0003 0001
E 0000 7ffe ffed feff
E 8002 0000 0006 0002
E edcd a468 2343 3401
E 0000 0200 1300 0100

// ==== rsa_core.f ====
common/rsa_pkg.sv
common/rsa_route_pkg.sv
hw/pe_array/pe_mac.sv
hw/pe_array/pe_array.sv
hw/bank_route/lane_select.sv
hw/bank_route/b_const_buf.sv
hw/bank_route/result_route.sv
hw/rsa_core.sv
dv/rsa_core_sva.sv
dv/rsa_core_tb.sv

// ==== dv/rsa_core_tb.sv ====
// systolic array core testbench
module rsa_core_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int ROWS    = rsa_pkg::ROWS_DEF;
  localparam int COLS    = rsa_pkg::COLS_DEF;
  localparam int LANES   = rsa_pkg::LANES_DEF;
  localparam int DATA_W  = rsa_pkg::DATA_W_DEF;
  localparam int MAXT    = 8;
  localparam int MAXK    = 8;
  localparam int TIMEOUT = 200;

  typedef logic [LANES-1:0][DATA_W-1:0] bank_t;

  logic                  clk;
  logic                  i_rst_n;
  bank_t                 i_tb_rdata;
  bank_t                 i_cb_rdata;
  rsa_route_pkg::route_e i_a_route;
  rsa_route_pkg::route_e i_b_route;
  rsa_route_pkg::route_e i_wb_route;
  logic                  i_b_load;
  logic                  i_b_use_const;
  logic                  i_cal_en;
  logic                  i_cal_done;
  bank_t                 o_tb_wdata;
  bank_t                 o_cb_wdata;
  logic [LANES-1:0]      o_tb_we;
  logic [LANES-1:0]      o_cb_we;

  // tiles from the golden file
  logic [8*16-1:0]   t_name  [MAXT];
  int                t_k     [MAXT];
  int                t_a     [MAXT];
  int                t_b     [MAXT];
  int                t_wb    [MAXT];
  int                t_const [MAXT];
  int                t_b2b   [MAXT];
  logic [DATA_W-1:0] c_word  [MAXT][COLS];
  bank_t             tb_beat [MAXT][MAXK];
  bank_t             cb_beat [MAXT][MAXK];
  logic [DATA_W-1:0] exp_w   [MAXT][ROWS][COLS];
  int                nt;

  // captured write beats
  logic [LANES-1:0] q_tb_we   [$];
  logic [LANES-1:0] q_cb_we   [$];
  bank_t            q_tb_data [$];
  bank_t            q_cb_data [$];

  int   errors;
  int   checks;
  logic done_sent;

  rsa_core uut (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .i_tb_rdata    (i_tb_rdata),
    .i_cb_rdata    (i_cb_rdata),
    .i_a_route     (i_a_route),
    .i_b_route     (i_b_route),
    .i_b_load      (i_b_load),
    .i_b_use_const (i_b_use_const),
    .i_cal_en      (i_cal_en),
    .i_cal_done    (i_cal_done),
    .i_wb_route    (i_wb_route),
    .o_tb_wdata    (o_tb_wdata),
    .o_cb_wdata    (o_cb_wdata),
    .o_tb_we       (o_tb_we),
    .o_cb_we       (o_cb_we)
  );

  always #5 clk = ~clk;

  // collect every write beat
  always @(posedge clk) begin
    if (i_rst_n && ((|o_tb_we) || (|o_cb_we))) begin
      // none may come before the first done
      assert (done_sent) else begin
        $display("write strobe seen before any tile was completed");
        errors++;
      end
      q_tb_we.push_back(o_tb_we);
      q_cb_we.push_back(o_cb_we);
      q_tb_data.push_back(o_tb_wdata);
      q_cb_data.push_back(o_cb_wdata);
    end
  end

  task automatic load_golden(input int fd);
    logic [8*16-1:0]   tag;
    logic [8*256-1:0]  junk;
    logic [8*16-1:0]   nm;
    logic [DATA_W-1:0] w [8];
    int                k, a, b, wb, cn, bb;
    int                nd, ne, rc;
    nt = 0;
    nd = 0;
    ne = 0;
    while ($fscanf(fd, "%s", tag) == 1) begin
      if (tag == "#") begin
        rc = $fgets(junk, fd);
      end else if (tag == "T") begin
        rc = $fscanf(fd, "%s %d %d %d %d %d %d", nm, k, a, b, wb, cn, bb);
        t_name[nt]  = nm;
        t_k[nt]     = k;
        t_a[nt]     = a;
        t_b[nt]     = b;
        t_wb[nt]    = wb;
        t_const[nt] = cn;
        t_b2b[nt]   = bb;
        nt++;
        nd = 0;
        ne = 0;
      end else if (tag == "C") begin
        rc = $fscanf(fd, "%h %h %h %h", w[0], w[1], w[2], w[3]);
        for (int c = 0; c < COLS; c++) begin
          c_word[nt-1][c] = w[c];
        end
      end else if (tag == "D") begin
        rc = $fscanf(fd, "%h %h %h %h %h %h %h %h",
                     w[0], w[1], w[2], w[3], w[4], w[5], w[6], w[7]);
        for (int l = 0; l < LANES; l++) begin
          tb_beat[nt-1][nd][l] = w[l];
          cb_beat[nt-1][nd][l] = w[LANES + l];
        end
        nd++;
      end else if (tag == "E") begin
        rc = $fscanf(fd, "%h %h %h %h", w[0], w[1], w[2], w[3]);
        for (int c = 0; c < COLS; c++) begin
          exp_w[nt-1][ne][c] = w[c];
        end
        ne++;
      end
    end
  endtask

  task automatic drive_tile(input int t);
    bank_t lane_w;
    // back-to-back tiles keep the routes of the tile before
    if (t_b2b[t] == 0) begin
      @(posedge clk);
      i_cal_done    <= 1'b0;
      i_b_use_const <= 1'b0;
      i_a_route     <= rsa_route_pkg::route_e'(t_a[t]);
      i_b_route     <= rsa_route_pkg::route_e'(t_b[t]);
      i_wb_route    <= rsa_route_pkg::route_e'(t_wb[t]);
    end
    // constant B goes in word by word on TB lane 0
    if (t_const[t] != 0) begin
      for (int c = 0; c < COLS; c++) begin
        @(posedge clk);
        lane_w     = '0;
        lane_w[0]  = c_word[t][c];
        i_b_load   <= 1'b1;
        i_tb_rdata <= lane_w;
      end
      @(posedge clk);
      i_b_load      <= 1'b0;
      i_b_use_const <= 1'b1;
    end
    for (int k = 0; k < t_k[t]; k++) begin
      @(posedge clk);
      i_tb_rdata <= tb_beat[t][k];
      i_cb_rdata <= cb_beat[t][k];
      i_cal_en   <= 1'b1;
      i_cal_done <= 1'b0;
    end
    @(posedge clk);
    i_cal_en   <= 1'b0;
    i_cal_done <= 1'b1;
    done_sent  <= 1'b1;
  endtask

  task automatic check_tile(input int t);
    int               cycles;
    int               lane;
    logic             to_cb;
    logic             rev;
    logic [LANES-1:0] exp_mask;
    logic [LANES-1:0] we_hit;
    logic [LANES-1:0] we_other;
    bank_t            data;
    to_cb = (t_wb[t] == rsa_route_pkg::SRC_CB_FWD) || (t_wb[t] == rsa_route_pkg::SRC_CB_REV);
    rev = (t_wb[t] == rsa_route_pkg::SRC_TB_REV) || (t_wb[t] == rsa_route_pkg::SRC_CB_REV);
    exp_mask = '0;
    for (int r = 0; r < ROWS; r++) begin
      exp_mask[rev ? LANES-1-r : r] = 1'b1;
    end
    for (int j = 0; j < COLS; j++) begin
      cycles = 0;
      while (q_tb_we.size() == 0 && cycles < TIMEOUT) begin
        @(posedge clk);
        cycles++;
      end
      if (q_tb_we.size() == 0) begin
        $display("timeout waiting for write beat %0d of tile %0s", j, t_name[t]);
        errors++;
        return;
      end
      we_hit   = to_cb ? q_cb_we[0] : q_tb_we[0];
      we_other = to_cb ? q_tb_we[0] : q_cb_we[0];
      data     = to_cb ? q_cb_data[0] : q_tb_data[0];
      void'(q_tb_we.pop_front());
      void'(q_cb_we.pop_front());
      void'(q_tb_data.pop_front());
      void'(q_cb_data.pop_front());
      checks++;
      assert (we_hit == exp_mask) else begin
        $display("** Error: %0s beat %0d strobe: expected %b, actual %b",
                 t_name[t], j, exp_mask, we_hit);
        errors++;
      end
      assert (we_other == '0) else begin
        $display("** Error: %0s beat %0d other bank strobe: expected %b, actual %b",
                 t_name[t], j, {LANES{1'b0}}, we_other);
        errors++;
      end
      for (int r = 0; r < ROWS; r++) begin
        lane = rev ? LANES-1-r : r;
        checks++;
        assert (data[lane] == exp_w[t][r][j]) else begin
          $display("** Error: %0s beat %0d row %0d: expected %h, actual %h",
                   t_name[t], j, r, exp_w[t][r][j], data[lane]);
          errors++;
        end
      end
    end
  endtask

  initial begin
    int fd;
    int pend;
    clk           = 1'b0;
    i_rst_n       = 1'b0;
    i_tb_rdata    = '0;
    i_cb_rdata    = '0;
    i_a_route     = rsa_route_pkg::SRC_TB_FWD;
    i_b_route     = rsa_route_pkg::SRC_TB_FWD;
    i_wb_route    = rsa_route_pkg::SRC_TB_FWD;
    i_b_load      = 1'b0;
    i_b_use_const = 1'b0;
    i_cal_en      = 1'b0;
    i_cal_done    = 1'b0;
    done_sent     = 1'b0;
    errors        = 0;
    checks        = 0;
    repeat (16) @(posedge clk);
    i_rst_n <= 1'b1;
    repeat (3) @(posedge clk);
    fd = $fopen("dv/rsa_core_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open the golden data file");
      errors++;
    end else begin
      load_golden(fd);
      $fclose(fd);
      if (nt == 0) begin
        $display("golden data file holds no tiles");
        errors++;
      end
      pend = 0;
      for (int t = 0; t < nt; t++) begin
        drive_tile(t);
        // check once no further tile follows straight on
        if (t == nt - 1 || t_b2b[t+1] == 0) begin
          @(posedge clk);
          i_cal_done <= 1'b0;
          for (int p = pend; p < t + 1; p++) begin
            check_tile(p);
          end
          pend = t + 1;
        end
      end
      repeat (10) @(posedge clk);
      // each tile drains exactly COLS beats
      checks++;
      assert (q_tb_we.size() == 0) else begin
        $display("%0d write beats arrived after the last tile was checked",
                 q_tb_we.size());
        errors++;
      end
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== dv/rsa_core_sva.sv ====
// write-back strobe assertions
module rsa_core_sva #(
  parameter int COLS  = rsa_pkg::COLS_DEF,
  parameter int LANES = rsa_pkg::LANES_DEF
) (
  input logic             clk,
  input logic             i_rst_n,
  input logic [LANES-1:0] o_tb_we,
  input logic [LANES-1:0] o_cb_we
);

  timeunit 1ns;
  timeprecision 1ps;

  logic wb_any;

  assign wb_any = (|o_tb_we) || (|o_cb_we);

  // one destination bank per beat
  a_one_bank: assert property (
    @(posedge clk) disable iff (!i_rst_n) !((|o_tb_we) && (|o_cb_we))
  ) else $error("write strobes active on both banks");

  // strobes cleared once reset has been seen on an edge
  a_reset_quiet: assert property (
    @(posedge clk) (!i_rst_n ##1 !i_rst_n) |-> (o_tb_we == '0 && o_cb_we == '0)
  ) else $error("write strobe active during reset");

  // a drain gives exactly one beat per column
  a_run_len: assert property (
    @(posedge clk) disable iff (!i_rst_n) $rose(wb_any) |-> wb_any [*COLS] ##1 !wb_any
  ) else $error("write beat run length differs from COLS");

endmodule

bind rsa_core rsa_core_sva #(
  .COLS  (COLS),
  .LANES (LANES)
) u_sva (
  .clk     (clk),
  .i_rst_n (i_rst_n),
  .o_tb_we (o_tb_we),
  .o_cb_we (o_cb_we)
);

// ==== hw/rsa_core.sv ====
// reconfigurable systolic array core
module rsa_core #(
  parameter int ROWS   = rsa_pkg::ROWS_DEF,
  parameter int COLS   = rsa_pkg::COLS_DEF,
  parameter int LANES  = rsa_pkg::LANES_DEF,
  parameter int DATA_W = rsa_pkg::DATA_W_DEF,
  parameter int ACC_W  = rsa_pkg::ACC_W_DEF
) (
  input  logic                         clk,
  input  logic                         i_rst_n,
  input  logic [LANES-1:0][DATA_W-1:0] i_tb_rdata,
  input  logic [LANES-1:0][DATA_W-1:0] i_cb_rdata,
  input  rsa_route_pkg::route_e        i_a_route,
  input  rsa_route_pkg::route_e        i_b_route,
  input  logic                         i_b_load,
  input  logic                         i_b_use_const,
  input  logic                         i_cal_en,
  input  logic                         i_cal_done,
  input  rsa_route_pkg::route_e        i_wb_route,
  output logic [LANES-1:0][DATA_W-1:0] o_tb_wdata,
  output logic [LANES-1:0][DATA_W-1:0] o_cb_wdata,
  output logic [LANES-1:0]             o_tb_we,
  output logic [LANES-1:0]             o_cb_we
);

  // row and column operand payloads
  typedef logic [ROWS-1:0][DATA_W-1:0] a_vec_t;
  typedef logic [COLS-1:0][DATA_W-1:0] b_vec_t;

  a_vec_t a_vec;
  b_vec_t b_routed;
  b_vec_t b_vec;
  logic   c_valid;
  a_vec_t c_col;

  // A operands, one word per row
  lane_select #(
    .LANES (LANES), .N (ROWS), .DATA_W (DATA_W), .T (a_vec_t)
  ) u_a_sel (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_tb_word (i_tb_rdata),
    .i_cb_word (i_cb_rdata),
    .i_route   (i_a_route),
    .o_vec     (a_vec)
  );

  // B operands, one word per column
  lane_select #(
    .LANES (LANES), .N (COLS), .DATA_W (DATA_W), .T (b_vec_t)
  ) u_b_sel (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_tb_word (i_tb_rdata),
    .i_cb_word (i_cb_rdata),
    .i_route   (i_b_route),
    .o_vec     (b_routed)
  );

  b_const_buf #(
    .COLS (COLS), .DATA_W (DATA_W)
  ) u_b_const (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_tb_lane0  (i_tb_rdata[0]),
    .i_b_load    (i_b_load),
    .i_use_const (i_b_use_const),
    .i_b_routed  (b_routed),
    .o_b_vec     (b_vec)
  );

  pe_array #(
    .ROWS (ROWS), .COLS (COLS), .DATA_W (DATA_W), .ACC_W (ACC_W)
  ) u_pe_array (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_a_vec    (a_vec),
    .i_b_vec    (b_vec),
    .i_cal_en   (i_cal_en),
    .i_cal_done (i_cal_done),
    .o_c_valid  (c_valid),
    .o_c_col    (c_col)
  );

  result_route #(
    .ROWS (ROWS), .LANES (LANES), .DATA_W (DATA_W)
  ) u_result_route (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_c_valid  (c_valid),
    .i_c_col    (c_col),
    .i_route    (i_wb_route),
    .o_tb_wdata (o_tb_wdata),
    .o_cb_wdata (o_cb_wdata),
    .o_tb_we    (o_tb_we),
    .o_cb_we    (o_cb_we)
  );

endmodule

// ==== hw/bank_route/result_route.sv ====
// result write-back steering
module result_route #(
  parameter int ROWS   = rsa_pkg::ROWS_DEF,
  parameter int LANES  = rsa_pkg::LANES_DEF,
  parameter int DATA_W = rsa_pkg::DATA_W_DEF
) (
  input  logic                         clk,
  input  logic                         i_rst_n,
  input  logic                         i_c_valid,
  input  logic [ROWS-1:0][DATA_W-1:0]  i_c_col,
  input  rsa_route_pkg::route_e        i_route,
  output logic [LANES-1:0][DATA_W-1:0] o_tb_wdata,
  output logic [LANES-1:0][DATA_W-1:0] o_cb_wdata,
  output logic [LANES-1:0]             o_tb_we,
  output logic [LANES-1:0]             o_cb_we
);

  logic [LANES-1:0][DATA_W-1:0] lane_word;
  logic [LANES-1:0]             lane_mask;
  logic                         to_cb;

  assign to_cb = rsa_route_pkg::route_is_cb(i_route);

  // row i lands on lane i or lane L-1-i
  always_comb begin
    lane_word = '0;
    lane_mask = '0;
    for (int r = 0; r < ROWS; r++) begin
      if (rsa_route_pkg::route_is_rev(i_route)) begin
        lane_word[LANES-1-r] = i_c_col[r];
        lane_mask[LANES-1-r] = 1'b1;
      end else begin
        lane_word[r] = i_c_col[r];
        lane_mask[r] = 1'b1;
      end
    end
  end

  // strobes only on drain beats, other bank held low
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_tb_we <= '0;
      o_cb_we <= '0;
    end else begin
      o_tb_we <= (i_c_valid && !to_cb) ? lane_mask : '0;
      o_cb_we <= (i_c_valid && to_cb) ? lane_mask : '0;
    end
  end

  // both banks see the words, the strobes decide
  always_ff @(posedge clk) begin
    o_tb_wdata <= lane_word;
    o_cb_wdata <= lane_word;
  end

endmodule

// ==== hw/bank_route/b_const_buf.sv ====
// constant B vector buffer
module b_const_buf #(
  parameter int COLS   = rsa_pkg::COLS_DEF,
  parameter int DATA_W = rsa_pkg::DATA_W_DEF
) (
  input  logic                        clk,
  input  logic                        i_rst_n,
  input  logic [DATA_W-1:0]           i_tb_lane0,
  input  logic                        i_b_load,
  input  logic                        i_use_const,
  input  logic [COLS-1:0][DATA_W-1:0] i_b_routed,
  output logic [COLS-1:0][DATA_W-1:0] o_b_vec
);

  // one extra count so a full buffer is visible
  localparam int PTR_W = $clog2(COLS + 1);

  logic [COLS-1:0][DATA_W-1:0] const_q;
  logic [PTR_W-1:0]            wr_ptr;
  logic                        wr_ok;

  // extra load beats past the last slot are dropped
  assign wr_ok = i_b_load && (wr_ptr < PTR_W'(COLS));

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
    end else if (!i_b_load) begin
      wr_ptr <= '0;
    end else if (wr_ok) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  // one word per load beat, slot 0 first
  always_ff @(posedge clk) begin
    if (wr_ok) begin
      const_q[wr_ptr] <= i_tb_lane0;
    end
  end

  // mux sits after the lane register, no extra cycle
  assign o_b_vec = i_use_const ? const_q : i_b_routed;

endmodule

// ==== hw/bank_route/lane_select.sv ====
// registered bank lane selector
module lane_select #(
  parameter int  LANES  = rsa_pkg::LANES_DEF,
  parameter int  N      = rsa_pkg::ROWS_DEF,
  parameter int  DATA_W = rsa_pkg::DATA_W_DEF,
  parameter type T      = logic [rsa_pkg::ROWS_DEF-1:0][rsa_pkg::DATA_W_DEF-1:0]
) (
  input  logic                         clk,
  input  logic                         i_rst_n,
  input  logic [LANES-1:0][DATA_W-1:0] i_tb_word,
  input  logic [LANES-1:0][DATA_W-1:0] i_cb_word,
  input  rsa_route_pkg::route_e        i_route,
  output T                             o_vec
);

  logic [LANES-1:0][DATA_W-1:0] bank;
  logic [N-1:0][DATA_W-1:0]     pick;

  always_comb begin
    // bank first, then lane order
    if (rsa_route_pkg::route_is_cb(i_route)) begin
      bank = i_cb_word;
    end else begin
      bank = i_tb_word;
    end
    // only the first N array lanes are used
    for (int n = 0; n < N; n++) begin
      if (rsa_route_pkg::route_is_rev(i_route)) begin
        pick[n] = bank[LANES-1-n];
      end else begin
        pick[n] = bank[n];
      end
    end
  end

  // one cycle from bank word to operand vector
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_vec <= '0;
    end else begin
      o_vec <= T'(pick);
    end
  end

endmodule

// ==== hw/pe_array/pe_array.sv ====
// systolic PE grid with skew and result drain
module pe_array #(
  parameter int ROWS   = rsa_pkg::ROWS_DEF,
  parameter int COLS   = rsa_pkg::COLS_DEF,
  parameter int DATA_W = rsa_pkg::DATA_W_DEF,
  parameter int ACC_W  = rsa_pkg::ACC_W_DEF
) (
  input  logic                         clk,
  input  logic                         i_rst_n,
  input  logic [ROWS-1:0][DATA_W-1:0]  i_a_vec,
  input  logic [COLS-1:0][DATA_W-1:0]  i_b_vec,
  input  logic                         i_cal_en,
  input  logic                         i_cal_done,
  output logic                         o_c_valid,
  output logic [ROWS-1:0][DATA_W-1:0]  o_c_col
);

  // A rows, then B columns, then drained result rows
  localparam int NSKEW = 2 * ROWS + COLS;
  localparam int CNT_W = $clog2(COLS + 1);

  logic              cal_en_q;
  logic              cal_done_q;
  logic [DATA_W-1:0] skew_in  [NSKEW];
  logic [DATA_W-1:0] skew_out [NSKEW];
  logic [DATA_W-1:0] east     [ROWS][COLS];
  logic [DATA_W-1:0] north    [ROWS][COLS];
  logic              en_o     [ROWS][COLS];
  logic              done_o   [ROWS][COLS];
  logic [DATA_W-1:0] drain_o  [ROWS][COLS];
  logic [CNT_W-1:0]  drain_cnt;
  // drain window per row, row i trails row 0 by i cycles
  logic [ROWS-1:0]   row_act;
  logic [ROWS-1:1]   act_q;

  // row end token of row 0 starts the drain
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      cal_en_q   <= 1'b0;
      cal_done_q <= 1'b0;
      drain_cnt  <= '0;
      act_q      <= '0;
    end else begin
      cal_en_q   <= i_cal_en;
      cal_done_q <= i_cal_done;
      if (done_o[0][COLS-1]) begin
        drain_cnt <= CNT_W'(COLS);
      end else if (drain_cnt != '0) begin
        drain_cnt <= drain_cnt - 1'b1;
      end
      act_q <= row_act[ROWS-2:0];
    end
  end

  assign row_act   = {act_q, drain_cnt != '0};
  assign o_c_valid = row_act[ROWS-1];

  always_comb begin
    for (int r = 0; r < ROWS; r++) begin
      skew_in[r]               = i_a_vec[r];
      skew_in[ROWS + COLS + r] = drain_o[r][0];
      o_c_col[r]               = skew_out[ROWS + COLS + r];
    end
    for (int c = 0; c < COLS; c++) begin
      skew_in[ROWS + c] = i_b_vec[c];
    end
  end

  // input skew by row or column index, output deskew by ROWS-1-row
  for (genvar n = 0; n < NSKEW; n++) begin : g_skew
    localparam int D = (n < ROWS) ? n :
                       (n < ROWS + COLS) ? n - ROWS : NSKEW - 1 - n;
    if (D == 0) begin : g_direct
      assign skew_out[n] = skew_in[n];
    end else begin : g_pipe
      logic [DATA_W-1:0] pipe [D];
      always_ff @(posedge clk) begin
        pipe[0] <= skew_in[n];
        for (int k = 1; k < D; k++) begin
          pipe[k] <= pipe[k-1];
        end
      end
      assign skew_out[n] = pipe[D-1];
    end
  end

  for (genvar i = 0; i < ROWS; i++) begin : g_row
    for (genvar j = 0; j < COLS; j++) begin : g_col
      logic [DATA_W-1:0] west_in;
      logic [DATA_W-1:0] south_in;
      logic              en_in;
      logic              done_in;
      logic [DATA_W-1:0] drain_in;

      if (j == 0) begin : g_w_edge
        assign west_in = skew_out[i];
      end else begin : g_w_link
        assign west_in = east[i][j-1];
      end
      if (i == 0) begin : g_s_edge
        assign south_in = skew_out[ROWS + j];
      end else begin : g_s_link
        assign south_in = north[i-1][j];
      end
      // tokens go east along row 0, then north up each column
      if (i == 0 && j == 0) begin : g_t_corner
        assign en_in   = cal_en_q;
        assign done_in = cal_done_q;
      end else if (i == 0) begin : g_t_east
        assign en_in   = en_o[0][j-1];
        assign done_in = done_o[0][j-1];
      end else begin : g_t_north
        assign en_in   = en_o[i-1][j];
        assign done_in = done_o[i-1][j];
      end
      // zeros fill in behind the drain
      if (j == COLS - 1) begin : g_d_edge
        assign drain_in = '0;
      end else begin : g_d_link
        assign drain_in = drain_o[i][j+1];
      end

      pe_mac #(
        .DATA_W (DATA_W),
        .ACC_W  (ACC_W)
      ) u_pe (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_west        (west_in),
        .i_south       (south_in),
        .i_cal_en      (en_in),
        .i_cal_done    (done_in),
        .i_drain_load  (done_o[i][COLS-1]),
        .i_drain_shift (row_act[i]),
        .i_drain_in    (drain_in),
        .o_east        (east[i][j]),
        .o_north       (north[i][j]),
        .o_cal_en      (en_o[i][j]),
        .o_cal_done    (done_o[i][j]),
        .o_drain_out   (drain_o[i][j])
      );
    end
  end

endmodule

// ==== hw/pe_array/pe_mac.sv ====
// multiply accumulate processing element
module pe_mac #(
  parameter int DATA_W = rsa_pkg::DATA_W_DEF,
  parameter int ACC_W  = rsa_pkg::ACC_W_DEF
) (
  input  logic              clk,
  input  logic              i_rst_n,
  input  logic [DATA_W-1:0] i_west,
  input  logic [DATA_W-1:0] i_south,
  input  logic              i_cal_en,
  input  logic              i_cal_done,
  input  logic              i_drain_load,
  input  logic              i_drain_shift,
  input  logic [DATA_W-1:0] i_drain_in,
  output logic [DATA_W-1:0] o_east,
  output logic [DATA_W-1:0] o_north,
  output logic              o_cal_en,
  output logic              o_cal_done,
  output logic [DATA_W-1:0] o_drain_out
);

  logic [2*DATA_W-1:0] prod;
  logic [ACC_W-1:0]    acc;
  // next cal_en starts a fresh sum
  logic                clr_pend;
  // snapshot taken when the done token passes
  logic [DATA_W-1:0]   result_q;
  logic [DATA_W-1:0]   drain_q;

  // unsigned product, low result bits do not depend on signedness
  assign prod = i_west * i_south;

  // tokens travel with the operands
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_cal_en   <= 1'b0;
      o_cal_done <= 1'b0;
      clr_pend   <= 1'b1;
    end else begin
      o_cal_en   <= i_cal_en;
      o_cal_done <= i_cal_done;
      if (i_cal_done) begin
        clr_pend <= 1'b1;
      end else if (i_cal_en) begin
        clr_pend <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    // operands move one PE per cycle
    o_east  <= i_west;
    o_north <= i_south;
    if (i_cal_en) begin
      if (clr_pend) begin
        acc <= ACC_W'(prod);
      end else begin
        acc <= acc + ACC_W'(prod);
      end
    end
    // sum is final while the done token sits here
    if (i_cal_done) begin
      result_q <= acc[DATA_W-1:0];
    end
    // load wins over shift
    if (i_drain_load) begin
      drain_q <= result_q;
    end else if (i_drain_shift) begin
      drain_q <= i_drain_in;
    end
  end

  assign o_drain_out = drain_q;

endmodule

// ==== common/rsa_route_pkg.sv ====
// bank lane routing codes
package rsa_route_pkg;

  // bit 1 picks the bank, bit 0 mirrors the lanes
  // write-back reuses the same codes for the destination
  typedef enum logic [1:0] {
    SRC_TB_FWD = 2'b00,
    SRC_TB_REV = 2'b01,
    SRC_CB_FWD = 2'b10,
    SRC_CB_REV = 2'b11
  } route_e;

  // covariance bank selected
  function automatic logic route_is_cb(input route_e r);
    return (r == SRC_CB_FWD) || (r == SRC_CB_REV);
  endfunction

  // lane i maps to lane L-1-i
  function automatic logic route_is_rev(input route_e r);
    return (r == SRC_TB_REV) || (r == SRC_CB_REV);
  endfunction

endpackage

// ==== common/rsa_pkg.sv ====
// systolic array geometry
package rsa_pkg;

  // PE grid size, X rows by Y columns
  // rows take the A operands
  localparam int ROWS_DEF = 4;

  // columns take the B operands
  localparam int COLS_DEF = 4;

  // word lanes per memory bank
  // must cover both ROWS_DEF and COLS_DEF
  localparam int LANES_DEF = 4;

  // operand and result word
  localparam int DATA_W_DEF = 16;

  // accumulator width
  // a full product plus guard bits for long tiles
  localparam int ACC_W_DEF = 40;

endpackage
